// File: peripheral_noc_switch.f
source/peripheral_noc_flit_pkg.sv
source/peripheral_noc_switch_pkg.sv
source/peripheral_arbiter_rr.sv
source/peripheral_noc_ingress.sv
source/peripheral_noc_out_port.sv
source/peripheral_noc_egress.sv
source/peripheral_noc_switch.sv
test/peripheral_noc_switch_tb.sv

// File: source/peripheral_arbiter_rr.sv
// Round-robin arbiter that derives the next one-hot grant from requests and the last grant
`timescale 1ns/10ps

module peripheral_arbiter_rr #(
  parameter int N = 2
) (
  input  logic [N-1:0] req,
  input  logic         en,
  input  logic [N-1:0] gnt,
  output logic [N-1:0] nxt_gnt
);

  ////////////////////////////////////////////////////////////////////////////
  // Priority masks
  ////////////////////////////////////////////////////////////////////////////

  // One mask per position
  // Bit p set when p lies cyclically between the last grant and this position
  logic [N-1:0] mask [N];

  always_comb begin : calc_mask
    logic run;
    int   p;
    run = 1'b1;
    p   = 0;
    for (int i = 0; i < N; i++) begin
      mask[i] = '0;
      // Chain restarts for every position
      run     = 1'b1;
      // Walk downward from i-1 with wrap
      for (int j = 1; j < N; j++) begin
        p          = (i - j + N) % N;
        // Chain breaks once the last grant is passed
        run        = run & ~gnt[p];
        mask[i][p] = run;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next grant
  ////////////////////////////////////////////////////////////////////////////

  genvar k;
  generate
    for (k = 0; k < N; k++) begin : gen_nxt_gnt
      // Requester wins when nobody with higher priority asks
      // No requests at all keeps the old grant
      assign nxt_gnt[k] = en ? ((~|(mask[k] & req) & req[k]) | (~|req & gnt[k]))
                             : gnt[k];
    end
  endgenerate

endmodule

// File: source/peripheral_noc_egress.sv
// Egress stage that registers the selected flits and folds link grants into queue pops
`timescale 1ns/10ps

module peripheral_noc_egress (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  peripheral_noc_switch_pkg::req_matrix_t grant,
  input  peripheral_noc_switch_pkg::flit_vec_t   sel_flit,
  input  peripheral_noc_switch_pkg::port_vec_t   sel_valid,
  output peripheral_noc_switch_pkg::port_vec_t   pop,
  output peripheral_noc_switch_pkg::flit_vec_t   out_flit,
  output peripheral_noc_switch_pkg::port_vec_t   out_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // Pop merge
  ////////////////////////////////////////////////////////////////////////////

  // Per-input pop is the OR over all outputs
  // At most one output grants a given input
  always_comb begin
    pop = '0;
    for (int k = 0; k < peripheral_noc_switch_pkg::NUM_PORTS; k++) begin
      pop = pop | grant[k];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Valid strobe, one cycle per transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= '0;
    end else begin
      out_valid <= sel_valid;
    end
  end

  // Flit data
  // idle link keeps its last flit
  always_ff @(posedge clk) begin
    for (int k = 0; k < peripheral_noc_switch_pkg::NUM_PORTS; k++) begin
      if (sel_valid[k]) begin
        out_flit[k] <= sel_flit[k];
      end
    end
  end

endmodule

// File: source/peripheral_noc_flit_pkg.sv
// Flit package for the peripheral NoC switch with field widths and flit layout

package peripheral_noc_flit_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////////////////////

  // Output link index carried in the flit
  localparam int DEST_W = 2;
  // Input link index, stamped by the ingress
  localparam int SRC_W = 2;
  // User data
  localparam int PAYLOAD_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Field types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [DEST_W-1:0]    dest_t;
  typedef logic [SRC_W-1:0]     src_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Single-flit packet with dest in the top bits
  typedef struct packed {
    dest_t    dest;
    src_t     src;
    payload_t payload;
  } flit_t;

endpackage

// File: source/peripheral_noc_ingress.sv
// Ingress stage with one flit queue per input link, source stamping and drop reporting
`timescale 1ns/10ps

module peripheral_noc_ingress (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  peripheral_noc_switch_pkg::flit_vec_t   in_flit,
  input  peripheral_noc_switch_pkg::port_vec_t   in_valid,
  input  peripheral_noc_switch_pkg::port_vec_t   pop,
  output peripheral_noc_switch_pkg::flit_vec_t   head,
  output peripheral_noc_switch_pkg::req_matrix_t req,
  output peripheral_noc_switch_pkg::port_vec_t   drop
);

  genvar g, k;
  generate
    for (g = 0; g < peripheral_noc_switch_pkg::NUM_PORTS; g++) begin : gen_queue

      //////////////////////////////////////////////////////////////////////////
      // Queue state
      //////////////////////////////////////////////////////////////////////////

      peripheral_noc_switch_pkg::qptr_t rd_ptr;
      peripheral_noc_switch_pkg::qptr_t wr_ptr;
      peripheral_noc_switch_pkg::qcnt_t cnt;
      peripheral_noc_flit_pkg::flit_t   wr_flit;
      logic                             full;
      logic                             empty;
      logic                             wr_en;
      logic                             rd_en;
      logic                             drop_q;

      // Circular storage
      peripheral_noc_flit_pkg::flit_t mem [peripheral_noc_switch_pkg::QUEUE_DEPTH];

      assign full  = (cnt == peripheral_noc_switch_pkg::qcnt_t'(
                       peripheral_noc_switch_pkg::QUEUE_DEPTH));
      assign empty = (cnt == '0);
      // Pop only ever arrives for a waiting head
      assign rd_en = pop[g] & ~empty;
      // A full queue still takes a flit when it pops on the same edge
      assign wr_en = in_valid[g] & (~full | rd_en);

      // Overwrite source with this link's index
      always_comb begin
        wr_flit     = in_flit[g];
        wr_flit.src = peripheral_noc_flit_pkg::src_t'(g);
      end

      always_ff @(posedge clk) begin
        if (wr_en) begin
          mem[wr_ptr] <= wr_flit;
        end
      end

      // Pointers wrap with the depth a power of two
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          rd_ptr <= '0;
          wr_ptr <= '0;
          cnt    <= '0;
          drop_q <= 1'b0;
        end else begin
          if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
          end
          if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
          end
          // Occupancy holds when both happen
          if (wr_en && !rd_en) begin
            cnt <= cnt + 1'b1;
          end else if (rd_en && !wr_en) begin
            cnt <= cnt - 1'b1;
          end
          // Strobe for one cycle on a lost flit
          drop_q <= in_valid[g] & full & ~rd_en;
        end
      end

      assign drop[g] = drop_q;
      assign head[g] = mem[rd_ptr];

      //////////////////////////////////////////////////////////////////////////
      // Request decode
      //////////////////////////////////////////////////////////////////////////

      // Head asks only the output named by its dest
      for (k = 0; k < peripheral_noc_switch_pkg::NUM_PORTS; k++) begin : gen_req
        assign req[k][g] = ~empty &
                           (mem[rd_ptr].dest == peripheral_noc_flit_pkg::dest_t'(k));
      end
    end
  endgenerate

endmodule

// File: source/peripheral_noc_out_port.sv
// Output link arbitration stage holding the round-robin state and picking the winning head
`timescale 1ns/10ps

module peripheral_noc_out_port (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  peripheral_noc_switch_pkg::port_vec_t req,
  input  peripheral_noc_switch_pkg::flit_vec_t head,
  output peripheral_noc_switch_pkg::port_vec_t grant,
  output peripheral_noc_flit_pkg::flit_t       sel_flit,
  output logic                                 sel_valid
);

  // Last winner on this link
  peripheral_noc_switch_pkg::port_vec_t prev_gnt;
  peripheral_noc_switch_pkg::port_vec_t nxt_gnt;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////////////////////

  // Any waiting input makes a transfer this cycle
  assign sel_valid = |req;

  peripheral_arbiter_rr #(
    .N       (peripheral_noc_switch_pkg::NUM_PORTS)
  ) arbiter_inst (
    .req     (req),
    .en      (sel_valid),
    .gnt     (prev_gnt),
    .nxt_gnt (nxt_gnt)
  );

  // Idle cycles hand back the old grant, so mask it out
  assign grant = nxt_gnt & req;

  // Mux granted head
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < peripheral_noc_switch_pkg::NUM_PORTS; i++) begin
      if (grant[i]) begin
        sel_flit = head[i];
      end
    end
  end

  // Top input starts as last winner so input 0 goes first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prev_gnt <= {1'b1, {(peripheral_noc_switch_pkg::NUM_PORTS-1){1'b0}}};
    end else if (sel_valid) begin
      prev_gnt <= grant;
    end
  end

endmodule

// File: source/peripheral_noc_switch.sv
// Four-link peripheral NoC switch with input queues and round-robin output links
`timescale 1ns/10ps

module peripheral_noc_switch (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  peripheral_noc_switch_pkg::flit_vec_t in_flit,
  input  peripheral_noc_switch_pkg::port_vec_t in_valid,
  output peripheral_noc_switch_pkg::flit_vec_t out_flit,
  output peripheral_noc_switch_pkg::port_vec_t out_valid,
  output peripheral_noc_switch_pkg::port_vec_t drop
);

  // Ingress to link stages
  peripheral_noc_switch_pkg::flit_vec_t   head;
  peripheral_noc_switch_pkg::req_matrix_t req;
  // Link stages to egress
  peripheral_noc_switch_pkg::req_matrix_t grant;
  peripheral_noc_switch_pkg::flit_vec_t   sel_flit;
  peripheral_noc_switch_pkg::port_vec_t   sel_valid;
  // Egress back to ingress
  peripheral_noc_switch_pkg::port_vec_t   pop;

  peripheral_noc_ingress ingress_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_flit  (in_flit),
    .in_valid (in_valid),
    .pop      (pop),
    .head     (head),
    .req      (req),
    .drop     (drop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output link stages
  ////////////////////////////////////////////////////////////////////////////

  genvar g;
  generate
    for (g = 0; g < peripheral_noc_switch_pkg::NUM_PORTS; g++) begin : gen_out_port
      peripheral_noc_out_port out_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req[g]),
        .head      (head),
        .grant     (grant[g]),
        .sel_flit  (sel_flit[g]),
        .sel_valid (sel_valid[g])
      );
    end
  endgenerate

  peripheral_noc_egress egress_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .sel_flit  (sel_flit),
    .sel_valid (sel_valid),
    .pop       (pop),
    .out_flit  (out_flit),
    .out_valid (out_valid)
  );

endmodule

// File: source/peripheral_noc_switch_pkg.sv
// Switch package for the peripheral NoC switch with port count, queue sizes and port vectors

package peripheral_noc_switch_pkg;

  // Links per direction
  localparam int NUM_PORTS = 4;

  // Input queue geometry
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = 2;
  // One extra bit so a full queue is distinct from an empty one
  localparam int QCNT_W      = 3;

  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QCNT_W-1:0] qcnt_t;

  // One bit per link
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // One flit per link
  typedef peripheral_noc_flit_pkg::flit_t [NUM_PORTS-1:0] flit_vec_t;

  // Indexed by output, one bit per input
  typedef port_vec_t [NUM_PORTS-1:0] req_matrix_t;

endpackage

// File: test/peripheral_noc_switch_tb.sv
// Testbench for the peripheral NoC switch, table and random traffic against a cycle model
`timescale 1ns/10ps

module peripheral_noc_switch_tb;

  localparam int NP    = peripheral_noc_switch_pkg::NUM_PORTS;
  localparam int DEPTH = peripheral_noc_switch_pkg::QUEUE_DEPTH;

  // One stimulus row where input i carries payload base + i
  typedef struct packed {
    peripheral_noc_switch_pkg::port_vec_t        valid;
    peripheral_noc_flit_pkg::dest_t [NP-1:0]     dest;
    peripheral_noc_flit_pkg::payload_t           base;
  } row_t;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  peripheral_noc_switch_pkg::flit_vec_t in_flit;
  peripheral_noc_switch_pkg::port_vec_t in_valid;
  peripheral_noc_switch_pkg::flit_vec_t out_flit;
  peripheral_noc_switch_pkg::port_vec_t out_valid;
  peripheral_noc_switch_pkg::port_vec_t drop;

  // Values on the DUT inputs up to the next edge
  peripheral_noc_switch_pkg::port_vec_t drv_valid;
  peripheral_noc_switch_pkg::flit_vec_t drv_flit;

  // Reference model state with the head at index 0
  peripheral_noc_flit_pkg::flit_t       mq [NP][DEPTH];
  int                                   mcnt [NP];
  int                                   prev_idx [NP];
  peripheral_noc_switch_pkg::port_vec_t exp_valid;
  peripheral_noc_switch_pkg::port_vec_t exp_drop;
  peripheral_noc_flit_pkg::flit_t       exp_flit [NP];

  // Bookkeeping
  int   n_sent;
  int   n_out;
  int   n_drop;
  row_t rows [$];

  always #5 clk = ~clk;

  peripheral_noc_switch peripheral_noc_switch_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .drop      (drop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch on %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_outputs();
    compare("out_valid", out_valid, exp_valid);
    compare("drop", drop, exp_drop);
    for (int k = 0; k < NP; k++) begin
      // Idle link data is not defined before its first transfer
      if (exp_valid[k]) begin
        compare($sformatf("out_flit[%0d]", k), out_flit[k], exp_flit[k]);
      end
    end
    n_out  += $countones(out_valid);
    n_drop += $countones(drop);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, one call per clock edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_step();
    peripheral_noc_switch_pkg::port_vec_t pop_v;
    peripheral_noc_switch_pkg::port_vec_t req_v;
    int   idx;
    logic found;
    pop_v = '0;
    for (int k = 0; k < NP; k++) begin
      req_v = '0;
      for (int i = 0; i < NP; i++) begin
        req_v[i] = (mcnt[i] > 0) && (mq[i][0].dest == k);
      end
      exp_valid[k] = |req_v;
      found = 1'b0;
      // Scan upward from the last winner, wrapping around
      for (int s = 1; s <= NP; s++) begin
        if (!found && req_v[(prev_idx[k] + s) % NP]) begin
          idx   = (prev_idx[k] + s) % NP;
          found = 1'b1;
        end
      end
      if (found) begin
        prev_idx[k]  = idx;
        exp_flit[k]  = mq[idx][0];
        pop_v[idx]   = 1'b1;
      end
    end
    for (int i = 0; i < NP; i++) begin
      // Lost only when full and not draining this edge
      exp_drop[i] = drv_valid[i] && (mcnt[i] == DEPTH) && !pop_v[i];
      if (pop_v[i]) begin
        for (int j = 0; j < DEPTH - 1; j++) begin
          mq[i][j] = mq[i][j+1];
        end
        mcnt[i]--;
      end
      if (drv_valid[i] && !exp_drop[i]) begin
        mq[i][mcnt[i]]     = drv_flit[i];
        mq[i][mcnt[i]].src = peripheral_noc_flit_pkg::src_t'(i);
        mcnt[i]++;
      end
      n_sent += drv_valid[i];
    end
  endtask

  function automatic logic model_busy();
    logic busy;
    busy = |drv_valid;
    for (int i = 0; i < NP; i++) begin
      busy = busy | (mcnt[i] > 0);
    end
    return busy;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic row_t make_row(input logic [NP-1:0] v, input logic [2*NP-1:0] dests,
                                    input logic [15:0] base);
    row_t r;
    r.valid = v;
    r.dest  = dests;
    r.base  = base;
    return r;
  endfunction

  // One clock of modelling and driving with the check at the falling edge
  task automatic step(input peripheral_noc_switch_pkg::port_vec_t v,
                      input peripheral_noc_switch_pkg::flit_vec_t f);
    @(posedge clk);
    model_step();
    in_valid  <= v;
    in_flit   <= f;
    drv_valid  = v;
    drv_flit   = f;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic apply_row(input row_t r);
    peripheral_noc_switch_pkg::flit_vec_t f;
    for (int i = 0; i < NP; i++) begin
      f[i].dest    = r.dest[i];
      // Junk source that the switch must overwrite
      f[i].src     = peripheral_noc_flit_pkg::src_t'(NP - 1 - i);
      f[i].payload = r.base + 16'(i);
    end
    step(r.valid, f);
  endtask

  initial begin
    int guard;
    void'($urandom(79));
    rst_n     = 1'b0;
    in_valid  = '0;
    in_flit   = '0;
    drv_valid = '0;
    drv_flit  = '0;
    exp_valid = '0;
    exp_drop  = '0;
    n_sent    = 0;
    n_out     = 0;
    n_drop    = 0;
    for (int i = 0; i < NP; i++) begin
      mcnt[i]     = 0;
      prev_idx[i] = NP - 1;
    end

    // Idle after reset, then one flit from input 2 to output 1
    repeat (3) rows.push_back(make_row(4'b0000, 8'h00, 16'h0000));
    rows.push_back(make_row(4'b0100, 8'h10, 16'hA5A0));
    rows.push_back(make_row(4'b0000, 8'h00, 16'h0000));
    // Everyone to output 3 while its grant is still at reset
    // Grants rise from input 0 as the queues drain
    rows.push_back(make_row(4'b1111, 8'hFF, 16'hC000));
    repeat (4) rows.push_back(make_row(4'b0000, 8'h00, 16'h0000));
    // Four disjoint paths at once
    rows.push_back(make_row(4'b1111, 8'h4E, 16'h1230));
    rows.push_back(make_row(4'b0000, 8'h00, 16'h0000));
    // Inputs 0 and 1 then 0 and 2 so rotation resumes after input 1
    rows.push_back(make_row(4'b0011, 8'h00, 16'h3300));
    repeat (2) rows.push_back(make_row(4'b0000, 8'h00, 16'h0000));
    rows.push_back(make_row(4'b0101, 8'h00, 16'h5500));
    repeat (2) rows.push_back(make_row(4'b0000, 8'h00, 16'h0000));
    // Sustained load on output 2 fills all queues
    for (int r = 0; r < 8; r++) begin
      rows.push_back(make_row(4'b1111, 8'hAA, 16'(16'hD000 + 16'(r << 4))));
    end
    // Seeded random traffic
    for (int r = 0; r < 200; r++) begin
      rows.push_back(make_row(4'($urandom), 8'($urandom), 16'($urandom)));
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    foreach (rows[r]) begin
      apply_row(rows[r]);
    end

    // Drain until the model is empty
    guard = 0;
    while (model_busy() && guard < 100) begin
      step('0, '0);
      guard++;
    end
    if (model_busy()) begin
      $display("Timed out waiting for the switch queues to drain");
      $display("STATUS: FAIL");
      $fatal(1);
    end else begin
      // Each flit either delivered once or dropped
      compare("delivered plus dropped", n_out + n_drop, n_sent);
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule
